/* source/ipsum_pkg.sv */
package ipsum_pkg;

    // data widths
    localparam int DATA_W = 32;         // one GLB word, one FIFO entry
    localparam int HALF_W = 16;         // one stored partial sum
    localparam int ADDR_W = 32;         // GLB byte address
    localparam int PTR_W  = 16;         // GLB read pointer
    localparam int CNT_W  = 32;         // job length and pop count

    // FIFO geometry
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_AW    = 2;

    // one PUSH visit may issue at most this many reads,
    // same as the depth so a single burst fills the FIFO
    localparam int BURST_REQS = 4;

    // which half of the GLB word is taken on a push
    localparam logic [1:0] LOAD_LO_HALF = 2'b01;
    localparam logic [1:0] LOAD_HI_HALF = 2'b10;

    // one GLB read word
    // viewed as a whole word or as two partial sums
    typedef union packed {
        logic [DATA_W-1:0]            word;
        logic [1:0][HALF_W-1:0]       half;     // half[0] sits at the lower address
    } glb_word_u;

    // fetch controller states
    typedef enum logic [1:0] {
        IDLE,       // no job, done is high
        CAN_POP,    // FIFO holds data, pops allowed
        PUSH,       // fetching a burst from the GLB
        WAIT        // GLB busy with another client
    } ipsum_state_e;

endpackage

/* source/ipsum_fifo_if.sv */
`timescale 1ns/10ps

interface ipsum_fifo_if;
    import ipsum_pkg::*;

    logic      push;
    glb_word_u push_data;
    logic      full;
    logic      pop;
    glb_word_u pop_data;    // head entry, valid whenever not empty
    logic      empty;

    // fetch controller side
    modport ctrl (
        output push,
        output push_data,
        output pop,
        input  full,
        input  empty
    );

    // storage side
    modport store (
        input  push,
        input  push_data,
        input  pop,
        output full,
        output empty,
        output pop_data
    );

    // accumulator taps the pop strobe and the head word
    modport sink (
        input  pop,
        input  pop_data
    );

endinterface

/* source/ipsum_fifo_ctrl.sv */
`timescale 1ns/10ps

module ipsum_fifo_ctrl (
    input  logic                        clk,
    input  logic                        rst_n,

    // job control from the layer controller
    input  logic                        glb_busy_i,
    input  logic                        fifo_reset_i,   // clears the read pointer only
    input  logic                        need_pop_i,
    input  logic [ipsum_pkg::CNT_W-1:0] pop_num_i,
    input  logic                        mask_i,

    // GLB read side
    input  logic                        permit_i,
    input  logic [ipsum_pkg::ADDR_W-1:0] base_addr_i,
    input  ipsum_pkg::glb_word_u        glb_read_data_i,
    output logic                        read_req_o,
    output logic [ipsum_pkg::ADDR_W-1:0] read_addr_o,

    // PE array side
    input  logic                        pe_move_i,
    output logic                        pop_state_o,
    output logic                        done_o,

    ipsum_fifo_if.ctrl                  fifo
);
    import ipsum_pkg::*;

    ipsum_state_e state_q;
    ipsum_state_e state_d;

    logic [CNT_W-1:0]                   pop_num_q;  // latched job length
    logic [CNT_W-1:0]                   pop_cnt_q;
    logic [PTR_W-1:0]                   read_ptr_q;
    logic [$clog2(BURST_REQS+1)-1:0]    req_cnt_q;  // permits seen in this PUSH visit
    logic                               push_q;
    logic [1:0]                         half_sel_q;
    glb_word_u                          push_word;
    logic                               pop;
    logic                               last_pop;

    // pop only when the PE array moves and the mask allows it
    assign pop = (state_q == CAN_POP) && !fifo.empty && pe_move_i && mask_i;
    assign last_pop = pop && (pop_cnt_q == pop_num_q - CNT_W'(1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (need_pop_i) begin
                    state_d = fifo.empty ? PUSH : CAN_POP;
                end
            end
            CAN_POP: begin
                if (last_pop) begin
                    state_d = IDLE;
                end else if (fifo.empty) begin
                    state_d = PUSH;     // ran dry, go refill
                end else if (glb_busy_i) begin
                    state_d = WAIT;
                end
            end
            PUSH: begin
                if (fifo.full) begin
                    state_d = glb_busy_i ? WAIT : CAN_POP;
                end
            end
            WAIT: begin
                if (!glb_busy_i) begin
                    state_d = CAN_POP;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    // job length, taken when the job starts
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pop_num_q <= '0;
        end else if (state_q == IDLE && need_pop_i) begin
            pop_num_q <= pop_num_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pop_cnt_q <= '0;
        end else if (state_q == IDLE) begin
            pop_cnt_q <= '0;
        end else if (pop) begin
            pop_cnt_q <= pop_cnt_q + CNT_W'(1);
        end
    end

    // read pointer walks the GLB in half-word steps
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            read_ptr_q <= '0;
        end else if (fifo_reset_i) begin
            read_ptr_q <= '0;
        end else if (permit_i) begin
            read_ptr_q <= read_ptr_q + PTR_W'(2);
        end
    end

    assign read_addr_o = base_addr_i + {{(ADDR_W-PTR_W){1'b0}}, read_ptr_q};

    // request limiter, restarts on every PUSH visit
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_cnt_q <= '0;
        end else if (state_q != PUSH) begin
            req_cnt_q <= '0;
        end else if (permit_i) begin
            req_cnt_q <= req_cnt_q + 1'b1;
        end
    end

    assign read_req_o = (state_q == PUSH) && !fifo.full && (req_cnt_q < BURST_REQS);

    // GLB data shows up one cycle after the permit, push lines up with it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            push_q     <= 1'b0;
            half_sel_q <= LOAD_LO_HALF;
        end else begin
            push_q <= permit_i && !fifo.full;
            if (permit_i) begin
                half_sel_q <= read_addr_o[1] ? LOAD_HI_HALF : LOAD_LO_HALF;
            end
        end
    end

    always_comb begin
        case (half_sel_q)
            LOAD_LO_HALF: push_word.word = {{(DATA_W-HALF_W){1'b0}}, glb_read_data_i.half[0]};
            LOAD_HI_HALF: push_word.word = {{(DATA_W-HALF_W){1'b0}}, glb_read_data_i.half[1]};
            default:      push_word.word = '0;
        endcase
    end

    assign fifo.push      = push_q;
    assign fifo.push_data = push_word;
    assign fifo.pop       = pop;

    assign done_o      = (state_q == IDLE);
    assign pop_state_o = (state_q == CAN_POP);

endmodule

/* source/ipsum_fifo.sv */
`timescale 1ns/10ps

module ipsum_fifo (
    input  logic        clk,
    input  logic        rst_n,

    ipsum_fifo_if.store fifo
);
    import ipsum_pkg::*;

    glb_word_u          mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr_q;
    logic [FIFO_AW-1:0] rd_ptr_q;
    logic [FIFO_AW:0]   count_q;    // one extra bit to tell full from empty
    logic               do_push;
    logic               do_pop;

    assign do_push = fifo.push && !fifo.full;
    assign do_pop  = fifo.pop && !fifo.empty;

    // storage array
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr_q] <= fifo.push_data;
        end
    end

    // pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    // occupancy
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q <= '0;
        end else begin
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;    // idle, or push and pop together
            endcase
        end
    end

    assign fifo.full     = (count_q == (FIFO_AW+1)'(FIFO_DEPTH));
    assign fifo.empty    = (count_q == '0);
    assign fifo.pop_data = mem[rd_ptr_q];   // show-ahead head

endmodule

/* source/ipsum_accum.sv */
`timescale 1ns/10ps

module ipsum_accum (
    input  logic                        clk,
    input  logic                        rst_n,

    input  logic [ipsum_pkg::DATA_W-1:0] pe_psum_i,    // product from the PE array
    output logic [ipsum_pkg::DATA_W-1:0] opsum_o,
    output logic                        opsum_valid_o,

    ipsum_fifo_if.sink                  fifo
);
    import ipsum_pkg::*;

    logic [DATA_W-1:0] sum_q;
    logic              valid_q;

    // head word is already on pop_data in the pop cycle
    always_ff @(posedge clk) begin
        if (fifo.pop) begin
            sum_q <= fifo.pop_data.word + pe_psum_i;    // carry out dropped
        end
    end

    // one valid per pop
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= fifo.pop;
        end
    end

    assign opsum_o       = sum_q;
    assign opsum_valid_o = valid_q;

endmodule

/* source/ipsum_path_top.sv */
`timescale 1ns/10ps

module ipsum_path_top (
    input  logic                         clk,
    input  logic                         rst_n,

    // layer controller
    input  logic                         glb_busy_i,
    input  logic                         fifo_reset_i,
    input  logic                         need_pop_i,
    input  logic [ipsum_pkg::CNT_W-1:0]  pop_num_i,
    input  logic                         mask_i,
    input  logic [ipsum_pkg::ADDR_W-1:0] base_addr_i,
    output logic                         done_o,

    // GLB and its arbiter
    input  logic                         glb_permit_i,
    input  logic [ipsum_pkg::DATA_W-1:0] glb_read_data_i,
    output logic                         glb_read_req_o,
    output logic [ipsum_pkg::ADDR_W-1:0] glb_read_addr_o,

    // PE array
    input  logic                         pe_move_i,
    input  logic [ipsum_pkg::DATA_W-1:0] pe_psum_i,
    output logic                         pop_state_o,
    output logic [ipsum_pkg::DATA_W-1:0] opsum_o,
    output logic                         opsum_valid_o
);

    ipsum_fifo_if i_fifo_if ();

    // fetch and pop control
    ipsum_fifo_ctrl i_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .glb_busy_i      (glb_busy_i),
        .fifo_reset_i    (fifo_reset_i),
        .need_pop_i      (need_pop_i),
        .pop_num_i       (pop_num_i),
        .mask_i          (mask_i),
        .permit_i        (glb_permit_i),
        .base_addr_i     (base_addr_i),
        .glb_read_data_i (glb_read_data_i),    // raw word, split into halves inside
        .read_req_o      (glb_read_req_o),
        .read_addr_o     (glb_read_addr_o),
        .pe_move_i       (pe_move_i),
        .pop_state_o     (pop_state_o),
        .done_o          (done_o),
        .fifo            (i_fifo_if.ctrl)
    );

    // partial sum buffer
    ipsum_fifo i_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .fifo  (i_fifo_if.store)
    );

    // output partial sum
    ipsum_accum i_accum (
        .clk           (clk),
        .rst_n         (rst_n),
        .pe_psum_i     (pe_psum_i),
        .opsum_o       (opsum_o),
        .opsum_valid_o (opsum_valid_o),
        .fifo          (i_fifo_if.sink)
    );

endmodule

/* test/tb_ipsum_path.sv */
`timescale 1ns/10ps

module tb_ipsum_path;
    import ipsum_pkg::*;

    localparam logic [ADDR_W-1:0] BASE_ADDR = 32'h0000_0100;
    localparam int                MEM_AW    = 8;
    localparam logic [DATA_W-1:0] PSUM_STEP = 32'h1357_9bdf;   // wraps so carries get dropped

    logic              clk = 1'b0;
    logic              rst_n;
    logic              glb_busy_i;
    logic              fifo_reset_i;
    logic              need_pop_i;
    logic [CNT_W-1:0]  pop_num_i;
    logic              mask_i;
    logic [ADDR_W-1:0] base_addr_i;
    logic              glb_permit_i;
    logic [DATA_W-1:0] glb_read_data_i;
    logic              pe_move_i;
    logic [DATA_W-1:0] pe_psum_i;
    logic              glb_read_req_o;
    logic [ADDR_W-1:0] glb_read_addr_o;
    logic              pop_state_o;
    logic              done_o;
    logic [DATA_W-1:0] opsum_o;
    logic              opsum_valid_o;

    logic [DATA_W-1:0] glb_mem [2**MEM_AW];
    logic [ADDR_W-1:0] grant_q [$];     // addresses of permitted reads
    logic [DATA_W-1:0] expect_q [$];    // partial sums in FIFO order
    logic [ADDR_W-1:0] grant_addr;
    logic [PTR_W-1:0]  next_ptr;        // model of the GLB read pointer
    integer            seed = 2623;
    int                grant_wait = -1;
    int                valid_cnt;
    int                value_errs;
    int                other_errs;

    ipsum_path_top i_dut (.*);

    initial begin
        forever #2 clk = ~clk;
    end

    // zero-extended half that a read of addr pushes
    function automatic logic [DATA_W-1:0] half_at(input logic [ADDR_W-1:0] addr);
        logic [DATA_W-1:0] w;
        w = glb_mem[addr[MEM_AW+1:2]];
        return addr[1] ? DATA_W'(w[DATA_W-1:HALF_W]) : DATA_W'(w[HALF_W-1:0]);
    endfunction

    function automatic string ctrl_state();
        ipsum_state_e s;
        s = i_dut.i_ctrl.state_q;
        return s.name();
    endfunction

    // arbiter grants after 0 to 2 cycles and the GLB answers one cycle later
    always @(negedge clk) begin
        if (glb_permit_i) begin
            glb_read_data_i = glb_mem[grant_addr[MEM_AW+1:2]];
        end else begin
            glb_read_data_i = 32'hdead_beef;
        end
        glb_permit_i = 1'b0;
        if (glb_read_req_o) begin
            if (grant_wait < 0) begin
                grant_wait = $unsigned($random(seed)) % 3;
            end
            if (grant_wait == 0) begin
                glb_permit_i = 1'b1;
                grant_addr   = glb_read_addr_o;
                grant_q.push_back(grant_addr);
                expect_q.push_back(half_at(grant_addr));
                grant_wait = -1;
            end else begin
                grant_wait--;
            end
        end
    end

    // output scoreboard and a new PE product for the next cycle
    always @(negedge clk) begin
        logic [DATA_W-1:0] exp_sum;
        if (opsum_valid_o) begin
            valid_cnt++;
            if (expect_q.size() == 0) begin
                $display("opsum_valid_o went high with no partial sum in flight");
                other_errs++;
            end else begin
                exp_sum = expect_q.pop_front() + pe_psum_i;
                check_word("opsum_o", opsum_o, exp_sum);
            end
        end
        pe_psum_i = pe_psum_i + PSUM_STEP;
    end

    task automatic check_word(input string name, input logic [DATA_W-1:0] got,
                              input logic [DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("ERROR %s: got 0x%08h, expected 0x%08h", name, got, exp);
            value_errs++;
        end
    endtask

    task automatic check_addr(input string name, input logic [ADDR_W-1:0] got,
                              input logic [ADDR_W-1:0] exp);
        if (got !== exp) begin
            $display("ERROR %s: got 0x%08h, expected 0x%08h", name, got, exp);
            value_errs++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
            value_errs++;
        end
    endtask

    task automatic start_job(input int pops);
        valid_cnt  = 0;
        need_pop_i = 1'b1;
        pop_num_i  = CNT_W'(pops);
        @(negedge clk);
        need_pop_i = 1'b0;
    endtask

    task automatic wait_done(input int limit);
        int n;
        n = 0;
        while (!done_o && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (!done_o) begin
            $display("done_o did not rise within %0d cycles, FSM in %s", limit, ctrl_state());
            other_errs++;
        end
        @(negedge clk);     // let the last output reach the scoreboard
    endtask

    task automatic wait_pop_state(input int limit);
        int n;
        n = 0;
        while (!pop_state_o && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (!pop_state_o) begin
            $display("pop_state_o did not rise within %0d cycles, FSM in %s", limit, ctrl_state());
            other_errs++;
        end
    endtask

    task automatic check_stalled(input int cycles, input logic exp_pop_state);
        repeat (cycles) begin
            @(negedge clk);
            check_bit("pop_state_o", pop_state_o, exp_pop_state);
            check_bit("opsum_valid_o", opsum_valid_o, 1'b0);
        end
    endtask

    // read addresses must walk on in half-word steps from the pointer model
    task automatic check_grants(input int n);
        logic [ADDR_W-1:0] exp_addr;
        if (grant_q.size() != n) begin
            $display("saw %0d GLB read permits, expected %0d", grant_q.size(), n);
            other_errs++;
        end
        while (grant_q.size() > 0) begin
            exp_addr = base_addr_i + ADDR_W'(next_ptr);
            check_addr("glb_read_addr_o", grant_q.pop_front(), exp_addr);
            next_ptr = next_ptr + PTR_W'(2);
        end
    endtask

    task automatic check_job(input int pops, input int grants, input int left);
        if (valid_cnt != pops) begin
            $display("saw %0d output partial sums, expected %0d", valid_cnt, pops);
            other_errs++;
        end
        if (expect_q.size() != left) begin
            $display("%0d partial sums left in the FIFO, expected %0d", expect_q.size(), left);
            other_errs++;
        end
        check_grants(grants);
    endtask

    task automatic reset_outputs();
        check_bit("done_o", done_o, 1'b1);
        check_bit("glb_read_req_o", glb_read_req_o, 1'b0);
        check_bit("pop_state_o", pop_state_o, 1'b0);
        check_bit("opsum_valid_o", opsum_valid_o, 1'b0);
    endtask

    task automatic single_burst();
        start_job(4);
        wait_done(60);
        check_job(4, 4, 0);
    endtask

    task automatic stall_gating();
        pe_move_i = 1'b0;
        start_job(4);
        wait_pop_state(60);
        check_stalled(6, 1'b1);
        pe_move_i = 1'b1;
        mask_i    = 1'b0;
        check_stalled(6, 1'b1);
        mask_i = 1'b1;
        wait_done(60);
        check_job(4, 4, 0);
    endtask

    task automatic busy_pause();
        pe_move_i = 1'b0;   // hold pops until busy is up
        start_job(4);
        wait_pop_state(60);
        glb_busy_i = 1'b1;
        check_stalled(1, 1'b0);
        pe_move_i = 1'b1;
        check_stalled(6, 1'b0);
        glb_busy_i = 1'b0;
        wait_done(60);
        check_job(4, 4, 0);
    endtask

    task automatic long_job_ptr_reset();
        start_job(10);
        wait_done(200);
        check_job(10, 12, 2);   // three bursts leave two entries behind
        fifo_reset_i = 1'b1;
        @(negedge clk);
        fifo_reset_i = 1'b0;
        next_ptr     = '0;
        start_job(4);
        wait_done(60);
        check_job(4, 4, 2);
    endtask

    initial begin
        rst_n           = 1'b0;
        glb_busy_i      = 1'b0;
        fifo_reset_i    = 1'b0;
        need_pop_i      = 1'b0;
        pop_num_i       = '0;
        mask_i          = 1'b1;
        base_addr_i     = BASE_ADDR;
        glb_permit_i    = 1'b0;
        glb_read_data_i = '0;
        pe_move_i       = 1'b1;
        pe_psum_i       = 32'h0000_1000;
        next_ptr        = '0;
        value_errs      = 0;
        other_errs      = 0;
        for (int i = 0; i < 2**MEM_AW; i++) begin
            glb_mem[i] = {~i[7:0], 8'hc3, 8'h5a, i[7:0]};
        end
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        reset_outputs();
        single_burst();
        stall_gating();
        busy_pause();
        long_job_ptr_reset();

        $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* build.f */
source/ipsum_pkg.sv
source/ipsum_fifo_if.sv
source/ipsum_fifo_ctrl.sv
source/ipsum_fifo.sv
source/ipsum_accum.sv
source/ipsum_path_top.sv
test/tb_ipsum_path.sv

/* Bender.yml */
package:
  name: ipsum_path

sources:
  - files:
      - source/ipsum_pkg.sv
      - source/ipsum_fifo_if.sv
      - source/ipsum_fifo_ctrl.sv
      - source/ipsum_fifo.sv
      - source/ipsum_accum.sv
      - source/ipsum_path_top.sv
  - target: test
    files:
      - test/tb_ipsum_path.sv
